//--- Makefile
TOP = cache_bank_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f ref_cache_bank.f -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf obj_dir

//--- design/cache_bank_core.sv
`timescale 1ns/1ns

module cache_bank_core #(
   parameter int SET_BITS  = cache_bank_pkg::DEF_SET_BITS,
   parameter int WAY_BITS  = cache_bank_pkg::DEF_WAY_BITS,
   localparam int TAG_BITS = cache_bank_pkg::LINE_ADDR_BITS - SET_BITS,
   localparam int WAYS     = 1 << WAY_BITS
) (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    req_valid,
   input  logic [cache_bank_pkg::REF_IDX_BITS-1:0] req_ref_idx,
   input  logic [cache_bank_pkg::BLK_X_BITS-1:0]   req_x,
   input  logic [cache_bank_pkg::BLK_Y_BITS-1:0]   req_y,
   input  logic                                    req_last,
   input  logic                                    hit_fifo_full,
   input  logic                                    miss_fifo_full,
   input  logic                                    rd_fifo_full,
   output logic                                    req_ready,
   output logic                                    hit_wr_en,
   output logic                                    miss_wr_en,
   output logic                                    rd_valid,
   output cache_bank_pkg::axi_addr_t               rd_addr,
   output logic [SET_BITS-1:0]                     res_set,
   output logic [WAY_BITS-1:0]                     res_way,
   output logic                                    res_last
);

   import cache_bank_pkg::*;

   localparam int XS = (SET_BITS + 1) / 2;
   localparam int YS = SET_BITS - XS;

   line_addr_t               req_line;
   logic [2*XS-1:0]          half_bits;
   logic [SET_BITS-1:0]      req_set;
   logic [SET_BITS-1:0]      rd_set;
   logic                     req_accept;
   logic                     item_valid;
   line_addr_t               item_line;
   logic [SET_BITS-1:0]      item_set;
   logic                     item_last;
   logic [TAG_BITS-1:0]      item_tag;
   logic [WAYS*TAG_BITS-1:0] rd_tags;
   logic [WAYS-1:0]          rd_valid_bits;
   logic [WAYS*WAY_BITS-1:0] rd_ages;
   logic                     fire;
   logic                     tag_wr_en;
   logic [WAY_BITS-1:0]      tag_wr_way;
   logic                     age_wr_en;
   logic [WAY_BITS-1:0]      used_way;

   // -------------------- set / tag split
   assign req_line  = {req_ref_idx, req_y, req_x};
   assign half_bits = {req_y[XS-1:0], req_x[XS-1:0]};
   assign req_set   = half_bits[SET_BITS-1:0];
   assign item_tag  = {item_line.ref_idx, item_line.y[BLK_Y_BITS-1:YS],
                       item_line.x[BLK_X_BITS-1:XS]};

   assign req_ready  = !item_valid || fire;
   assign req_accept = req_valid && req_ready;
   assign rd_set     = req_accept ? req_set : item_set;   // hold read while stalled

   // -------------------- request register
   always_ff @(posedge clk) begin
      if (reset) begin
         item_valid <= 1'b0;
      end else if (req_accept) begin
         item_valid <= 1'b1;
      end else if (fire) begin
         item_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (req_accept) begin
         item_line <= req_line;
         item_set  <= req_set;
         item_last <= req_last;
      end
   end

   tag_memory #(.SET_BITS(SET_BITS), .WAY_BITS(WAY_BITS)) tag_memory_i (
      .clk           (clk),
      .reset         (reset),
      .rd_set        (rd_set),
      .wr_set        (item_set),
      .wr_way        (tag_wr_way),
      .wr_tag        (item_tag),
      .wr_en         (tag_wr_en),
      .rd_tags       (rd_tags),
      .rd_valid_bits (rd_valid_bits)
   );

   lru_age_memory #(.SET_BITS(SET_BITS), .WAY_BITS(WAY_BITS)) lru_age_memory_i (
      .clk      (clk),
      .reset    (reset),
      .rd_set   (rd_set),
      .wr_set   (item_set),
      .used_way (used_way),
      .wr_en    (age_wr_en),
      .rd_ages  (rd_ages)
   );

   tag_compare_stage #(.SET_BITS(SET_BITS), .WAY_BITS(WAY_BITS)) tag_compare_stage_i (
      .clk            (clk),
      .reset          (reset),
      .item_valid     (item_valid),
      .item_line      (item_line),
      .item_set       (item_set),
      .item_last      (item_last),
      .rd_tags        (rd_tags),
      .rd_valid_bits  (rd_valid_bits),
      .rd_ages        (rd_ages),
      .hit_fifo_full  (hit_fifo_full),
      .miss_fifo_full (miss_fifo_full),
      .rd_fifo_full   (rd_fifo_full),
      .fire           (fire),
      .tag_wr_en      (tag_wr_en),
      .tag_wr_way     (tag_wr_way),
      .age_wr_en      (age_wr_en),
      .used_way       (used_way),
      .hit_wr_en      (hit_wr_en),
      .miss_wr_en     (miss_wr_en),
      .rd_valid       (rd_valid),
      .rd_addr        (rd_addr),
      .res_set        (res_set),
      .res_way        (res_way),
      .res_last       (res_last)
   );

   a_ready_after_reset : assert property (@(posedge clk) $fell(reset) |-> req_ready);

endmodule

//--- design/cache_bank_pkg.sv
package cache_bank_pkg;

   // -------------------- line address
   localparam int REF_IDX_BITS   = 2;
   localparam int BLK_X_BITS     = 5;
   localparam int BLK_Y_BITS     = 5;
   localparam int LINE_ADDR_BITS = REF_IDX_BITS + BLK_Y_BITS + BLK_X_BITS;

   typedef struct packed {
      logic [REF_IDX_BITS-1:0] ref_idx;
      logic [BLK_Y_BITS-1:0]   y;        // block row
      logic [BLK_X_BITS-1:0]   x;        // block column
   } line_addr_t;

   // -------------------- external bus
   localparam int AXI_ADDR_BITS   = 32;
   localparam int LINE_BYTES_LOG2 = 6;   // 64 byte lines

   typedef logic [AXI_ADDR_BITS-1:0] axi_addr_t;

   // -------------------- default geometry
   localparam int DEF_SET_BITS = 4;
   localparam int DEF_WAY_BITS = 2;

   typedef enum logic {
      RES_HIT  = 1'b0,
      RES_MISS = 1'b1
   } result_kind_e;

endpackage

//--- design/lru_age_memory.sv
`timescale 1ns/1ns

module lru_age_memory #(
   parameter int SET_BITS = cache_bank_pkg::DEF_SET_BITS,
   parameter int WAY_BITS = cache_bank_pkg::DEF_WAY_BITS,
   localparam int WAYS    = 1 << WAY_BITS
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [SET_BITS-1:0]      rd_set,
   input  logic [SET_BITS-1:0]      wr_set,
   input  logic [WAY_BITS-1:0]      used_way,
   input  logic                     wr_en,
   output logic [WAYS*WAY_BITS-1:0] rd_ages
);

   localparam int SETS = 1 << SET_BITS;

   logic [WAYS*WAY_BITS-1:0] age_mem [SETS];
   logic [WAYS*WAY_BITS-1:0] init_row;
   logic [WAYS*WAY_BITS-1:0] old_row;
   logic [WAYS*WAY_BITS-1:0] new_row;
   logic [WAY_BITS-1:0]      used_age;
   logic [WAY_BITS-1:0]      cur_age;

   function automatic logic ages_unique(input logic [WAYS*WAY_BITS-1:0] row);
      logic [WAYS-1:0] seen;
      seen = '0;
      for (int w = 0; w < WAYS; w++) begin
         seen[row[w*WAY_BITS +: WAY_BITS]] = 1'b1;
      end
      return &seen;
   endfunction

   for (genvar w = 0; w < WAYS; w++) begin : g_init
      assign init_row[w*WAY_BITS +: WAY_BITS] = WAY_BITS'(w);   // way i starts at age i
   end

   // -------------------- age update
   always_comb begin
      old_row  = age_mem[wr_set];
      used_age = old_row[used_way*WAY_BITS +: WAY_BITS];
      new_row  = old_row;
      cur_age  = '0;
      for (int w = 0; w < WAYS; w++) begin
         cur_age = old_row[w*WAY_BITS +: WAY_BITS];
         if (used_way == WAY_BITS'(w)) begin
            new_row[w*WAY_BITS +: WAY_BITS] = '0;   // newest
         end else if (cur_age < used_age) begin
            new_row[w*WAY_BITS +: WAY_BITS] = cur_age + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < SETS; s++) begin
            age_mem[s] <= init_row;
         end
      end else if (wr_en) begin
         age_mem[wr_set] <= new_row;
      end
   end

   always_ff @(posedge clk) begin
      rd_ages <= (wr_en && wr_set == rd_set) ? new_row : age_mem[rd_set];
   end

   // stored ages stay a permutation across updates
   a_ages_perm : assert property (@(posedge clk) disable iff (reset)
      wr_en |=> ages_unique(age_mem[$past(wr_set)]));

endmodule

//--- design/tag_compare_stage.sv
`timescale 1ns/1ns

module tag_compare_stage #(
   parameter int SET_BITS  = cache_bank_pkg::DEF_SET_BITS,
   parameter int WAY_BITS  = cache_bank_pkg::DEF_WAY_BITS,
   localparam int TAG_BITS = cache_bank_pkg::LINE_ADDR_BITS - SET_BITS,
   localparam int WAYS     = 1 << WAY_BITS
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       item_valid,
   input  cache_bank_pkg::line_addr_t item_line,
   input  logic [SET_BITS-1:0]        item_set,
   input  logic                       item_last,
   input  logic [WAYS*TAG_BITS-1:0]   rd_tags,
   input  logic [WAYS-1:0]            rd_valid_bits,
   input  logic [WAYS*WAY_BITS-1:0]   rd_ages,
   input  logic                       hit_fifo_full,
   input  logic                       miss_fifo_full,
   input  logic                       rd_fifo_full,
   output logic                       fire,
   output logic                       tag_wr_en,
   output logic [WAY_BITS-1:0]        tag_wr_way,
   output logic                       age_wr_en,
   output logic [WAY_BITS-1:0]        used_way,
   output logic                       hit_wr_en,
   output logic                       miss_wr_en,
   output logic                       rd_valid,
   output cache_bank_pkg::axi_addr_t  rd_addr,
   output logic [SET_BITS-1:0]        res_set,
   output logic [WAY_BITS-1:0]        res_way,
   output logic                       res_last
);

   import cache_bank_pkg::*;

   localparam int XS = (SET_BITS + 1) / 2;   // column bits in the set
   localparam int YS = SET_BITS - XS;        // row bits in the set

   logic [TAG_BITS-1:0] item_tag;
   logic [WAYS-1:0]     hit_vec;
   logic [WAY_BITS-1:0] hit_way;
   logic [WAY_BITS-1:0] victim_way;
   logic [WAY_BITS-1:0] oldest_age;
   result_kind_e        kind;
   axi_addr_t           line_ext;

   assign item_tag = {item_line.ref_idx, item_line.y[BLK_Y_BITS-1:YS],
                      item_line.x[BLK_X_BITS-1:XS]};

   // -------------------- lookup
   always_comb begin
      hit_vec = '0;
      for (int w = 0; w < WAYS; w++) begin
         hit_vec[w] = rd_valid_bits[w] && (rd_tags[w*TAG_BITS +: TAG_BITS] == item_tag);
      end
   end

   always_comb begin
      hit_way = '0;
      for (int w = WAYS - 1; w >= 0; w--) begin
         if (hit_vec[w]) begin
            hit_way = WAY_BITS'(w);
         end
      end
   end

   assign kind = (|hit_vec) ? RES_HIT : RES_MISS;

   // lowest invalid way wins, else the oldest
   always_comb begin
      victim_way = '0;
      oldest_age = '0;
      for (int w = 0; w < WAYS; w++) begin
         if (rd_ages[w*WAY_BITS +: WAY_BITS] > oldest_age) begin
            oldest_age = rd_ages[w*WAY_BITS +: WAY_BITS];
            victim_way = WAY_BITS'(w);
         end
      end
      for (int w = WAYS - 1; w >= 0; w--) begin
         if (!rd_valid_bits[w]) begin
            victim_way = WAY_BITS'(w);
         end
      end
   end

   // -------------------- fire and writes
   always_comb begin
      if (kind == RES_HIT) begin
         fire = item_valid && !hit_fifo_full;
      end else begin
         fire = item_valid && !miss_fifo_full && !rd_fifo_full;
      end
   end

   assign used_way   = (kind == RES_HIT) ? hit_way : victim_way;
   assign tag_wr_en  = fire && (kind == RES_MISS);
   assign tag_wr_way = victim_way;
   assign age_wr_en  = fire;   // ages move on hit and miss
   assign line_ext   = {{(AXI_ADDR_BITS - LINE_ADDR_BITS){1'b0}}, item_line};

   // -------------------- queue outputs
   always_ff @(posedge clk) begin
      if (reset) begin
         hit_wr_en  <= 1'b0;
         miss_wr_en <= 1'b0;
         rd_valid   <= 1'b0;
      end else begin
         hit_wr_en  <= fire && (kind == RES_HIT);
         miss_wr_en <= fire && (kind == RES_MISS);
         rd_valid   <= fire && (kind == RES_MISS);
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         res_set  <= item_set;
         res_way  <= used_way;
         res_last <= item_last;
         rd_addr  <= line_ext << LINE_BYTES_LOG2;
      end
   end

   a_one_queue : assert property (@(posedge clk) disable iff (reset)
      !(hit_wr_en && miss_wr_en) && (rd_valid == miss_wr_en));

endmodule

//--- design/tag_memory.sv
`timescale 1ns/1ns

module tag_memory #(
   parameter int SET_BITS = cache_bank_pkg::DEF_SET_BITS,
   parameter int WAY_BITS = cache_bank_pkg::DEF_WAY_BITS,
   localparam int TAG_BITS = cache_bank_pkg::LINE_ADDR_BITS - SET_BITS,
   localparam int WAYS     = 1 << WAY_BITS
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [SET_BITS-1:0]      rd_set,
   input  logic [SET_BITS-1:0]      wr_set,
   input  logic [WAY_BITS-1:0]      wr_way,
   input  logic [TAG_BITS-1:0]      wr_tag,
   input  logic                     wr_en,
   output logic [WAYS*TAG_BITS-1:0] rd_tags,
   output logic [WAYS-1:0]          rd_valid_bits
);

   localparam int SETS = 1 << SET_BITS;

   logic [WAYS*TAG_BITS-1:0] tag_mem [SETS];
   logic [WAYS-1:0]          valid_mem [SETS];
   logic [WAYS*TAG_BITS-1:0] wr_row;
   logic [WAYS-1:0]          wr_valid_row;
   logic                     bypass;

   // row after the write, one way replaced
   always_comb begin
      wr_row       = tag_mem[wr_set];
      wr_valid_row = valid_mem[wr_set];
      wr_row[wr_way*TAG_BITS +: TAG_BITS] = wr_tag;
      wr_valid_row[wr_way] = 1'b1;
   end

   assign bypass = wr_en && (wr_set == rd_set);   // write-first

   always_ff @(posedge clk) begin
      if (wr_en) begin
         tag_mem[wr_set] <= wr_row;
      end
      rd_tags <= bypass ? wr_row : tag_mem[rd_set];
   end

   // -------------------- valid bits
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < SETS; s++) begin
            valid_mem[s] <= '0;
         end
      end else if (wr_en) begin
         valid_mem[wr_set] <= wr_valid_row;
      end
   end

   always_ff @(posedge clk) begin
      rd_valid_bits <= bypass ? wr_valid_row : valid_mem[rd_set];
   end

endmodule

//--- dv/cache_bank_tb.sv
`timescale 1ns/1ns

module cache_bank_tb;

   import cache_bank_pkg::*;

   localparam int ACCEPT_TIMEOUT = 200;
   localparam int DRAIN_TIMEOUT  = 400;

   typedef struct {
      logic [REF_IDX_BITS-1:0] ref_idx;
      logic [BLK_X_BITS-1:0]   x;
      logic [BLK_Y_BITS-1:0]   y;
      logic                    last;
      result_kind_e            kind;
      logic [DEF_WAY_BITS-1:0] way;
   } req_row_t;

   logic                    clk;
   logic                    reset;
   logic                    req_valid;
   logic [REF_IDX_BITS-1:0] req_ref_idx;
   logic [BLK_X_BITS-1:0]   req_x;
   logic [BLK_Y_BITS-1:0]   req_y;
   logic                    req_last;
   logic                    hit_fifo_full;
   logic                    miss_fifo_full;
   logic                    rd_fifo_full;
   logic                    req_ready;
   logic                    hit_wr_en;
   logic                    miss_wr_en;
   logic                    rd_valid;
   axi_addr_t               rd_addr;
   logic [DEF_SET_BITS-1:0] res_set;
   logic [DEF_WAY_BITS-1:0] res_way;
   logic                    res_last;

   req_row_t table_q[$];
   int       result_count = 0;   // pulses seen since time zero
   int       pass_start;
   int       pass_num;
   logic     bp_on;
   integer   seed;
   logic     prev_hit_full;
   logic     prev_miss_full;
   logic     prev_rd_full;

   cache_bank_core cache_bank_core_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // -------------------- failure reporting
   task automatic abort_run();
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_kind(input string name, input result_kind_e exp,
                             input result_kind_e act);
      if (exp !== act) begin
         $display("[FAIL] %s kind expected %s actual %s", name, exp.name(), act.name());
         abort_run();
      end
   endtask

   task automatic check_way(input string name, input logic [DEF_WAY_BITS-1:0] exp,
                            input logic [DEF_WAY_BITS-1:0] act);
      if (exp !== act) begin
         $display("[FAIL] %s way expected %0d actual %0d", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_set(input string name, input logic [DEF_SET_BITS-1:0] exp,
                            input logic [DEF_SET_BITS-1:0] act);
      if (exp !== act) begin
         $display("[FAIL] %s set expected %0d actual %0d", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("[FAIL] %s expected %b actual %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_addr(input string name, input axi_addr_t exp, input axi_addr_t act);
      if (exp !== act) begin
         $display("[FAIL] %s rd_addr expected 0x%08h actual 0x%08h", name, exp, act);
         abort_run();
      end
   endtask

   // -------------------- request table
   task automatic add_row(input int ref_idx, input int x, input int y, input bit last,
                          input result_kind_e kind, input int way);
      req_row_t r;
      r.ref_idx = REF_IDX_BITS'(ref_idx);
      r.x       = BLK_X_BITS'(x);
      r.y       = BLK_Y_BITS'(y);
      r.last    = last;
      r.kind    = kind;
      r.way     = DEF_WAY_BITS'(way);
      table_q.push_back(r);
   endtask

   task automatic build_table();
      add_row(0,  0, 0, 0, RES_MISS, 0);   // fill set 0
      add_row(0,  4, 0, 0, RES_MISS, 1);
      add_row(0,  8, 0, 0, RES_MISS, 2);
      add_row(0,  0, 4, 1, RES_MISS, 3);
      add_row(0,  8, 0, 0, RES_HIT,  2);   // revisit out of order
      add_row(0,  0, 0, 1, RES_HIT,  0);
      add_row(0,  0, 4, 0, RES_HIT,  3);
      add_row(0,  4, 0, 1, RES_HIT,  1);
      add_row(1,  0, 0, 0, RES_MISS, 2);   // evicts oldest
      add_row(0,  1, 1, 0, RES_MISS, 0);   // set 5
      add_row(2,  5, 1, 1, RES_MISS, 1);
      add_row(0,  8, 0, 0, RES_MISS, 0);
      add_row(0,  0, 0, 0, RES_MISS, 3);
      add_row(0,  1, 1, 1, RES_HIT,  0);
      add_row(1,  0, 0, 0, RES_HIT,  2);
      add_row(0,  4, 0, 0, RES_HIT,  1);
      add_row(0,  0, 4, 1, RES_MISS, 0);
      add_row(2,  5, 1, 0, RES_HIT,  1);
      add_row(3, 30, 2, 0, RES_MISS, 0);   // set 10, back to back
      add_row(3, 30, 2, 1, RES_HIT,  0);
   endtask

   // -------------------- queue back-pressure
   initial begin : full_flag_driver
      int rnd;
      seed           = 32'h1d59;
      hit_fifo_full  = 1'b0;
      miss_fifo_full = 1'b0;
      rd_fifo_full   = 1'b0;
      forever begin
         @(posedge clk);
         #10;
         rnd = $random(seed);
         hit_fifo_full  = bp_on && (rnd[1:0] == 2'b00);
         miss_fifo_full = bp_on && (rnd[3:2] == 2'b00);
         rd_fifo_full   = bp_on && (rnd[5:4] == 2'b00);
      end
   end

   // -------------------- result collection
   task automatic check_result();
      req_row_t                r;
      string                   name;
      int                      idx;
      axi_addr_t               exp_addr;
      logic [DEF_SET_BITS-1:0] exp_set;
      idx = result_count - pass_start;
      if (idx >= table_q.size()) begin
         $display("extra queue write enable after all %0d requests of pass %0d",
                  table_q.size(), pass_num);
         abort_run();
      end else begin
         r        = table_q[idx];
         name     = $sformatf("pass %0d row %0d", pass_num, idx);
         exp_set  = {r.y[1:0], r.x[1:0]};
         exp_addr = axi_addr_t'({r.ref_idx, r.y, r.x}) << LINE_BYTES_LOG2;
         check_kind(name, r.kind, hit_wr_en ? RES_HIT : RES_MISS);
         check_flag({name, " miss_wr_en"}, r.kind == RES_MISS, miss_wr_en);
         check_flag({name, " rd_valid"}, r.kind == RES_MISS, rd_valid);
         check_way(name, r.way, res_way);
         check_set(name, exp_set, res_set);
         check_flag({name, " res_last"}, r.last, res_last);
         if (r.kind == RES_MISS) begin
            check_addr(name, exp_addr, rd_addr);
         end
         result_count++;
      end
   endtask

   always @(negedge clk) begin
      if (!reset) begin
         if (hit_wr_en && prev_hit_full) begin
            $display("hit queue written although hit_fifo_full was high");
            abort_run();
         end
         if (miss_wr_en && (prev_miss_full || prev_rd_full)) begin
            $display("miss or read queue written although its full flag was high");
            abort_run();
         end
         if (rd_valid && prev_rd_full) begin
            $display("read address queue written although rd_fifo_full was high");
            abort_run();
         end
         if (hit_wr_en || miss_wr_en || rd_valid) begin
            check_result();
         end
      end
      prev_hit_full  = hit_fifo_full;
      prev_miss_full = miss_fifo_full;
      prev_rd_full   = rd_fifo_full;
   end

   // -------------------- driving
   task automatic apply_reset();
      @(posedge clk);
      #10;
      reset = 1'b1;
      repeat (10) @(posedge clk);
      #10;
      reset = 1'b0;
      @(negedge clk);
      check_flag("after reset hit_wr_en", 1'b0, hit_wr_en);
      check_flag("after reset miss_wr_en", 1'b0, miss_wr_en);
      check_flag("after reset rd_valid", 1'b0, rd_valid);
      check_flag("after reset req_ready", 1'b1, req_ready);
   endtask

   task automatic send_request(input req_row_t r);
      int waited;
      req_valid   = 1'b1;
      req_ref_idx = r.ref_idx;
      req_x       = r.x;
      req_y       = r.y;
      req_last    = r.last;
      waited      = 0;
      @(negedge clk);
      while (!req_ready) begin
         if (waited == ACCEPT_TIMEOUT) begin
            $display("timeout: request never accepted in pass %0d", pass_num);
            abort_run();
         end
         waited++;
         @(negedge clk);
      end
      @(posedge clk);   // accepted here
      #10;
   endtask

   task automatic wait_for_results();
      int waited;
      waited = 0;
      while (result_count - pass_start < table_q.size()) begin
         if (waited == DRAIN_TIMEOUT) begin
            $display("timeout: pass %0d produced only %0d of %0d results", pass_num,
                     result_count - pass_start, table_q.size());
            abort_run();
         end
         waited++;
         @(posedge clk);
      end
      repeat (4) @(posedge clk);   // any stray pulse shows up here
   endtask

   task automatic run_pass(input int num);
      pass_num = num;
      bp_on    = 1'b0;
      apply_reset();
      pass_start = result_count;
      bp_on      = (num == 1);
      @(posedge clk);
      #10;
      foreach (table_q[i]) begin
         send_request(table_q[i]);
      end
      req_valid = 1'b0;
      wait_for_results();
   endtask

   initial begin
      reset       = 1'b1;
      req_valid   = 1'b0;
      req_ref_idx = '0;
      req_x       = '0;
      req_y       = '0;
      req_last    = 1'b0;
      bp_on       = 1'b0;
      pass_num    = 0;
      pass_start  = 0;
      build_table();
      run_pass(0);
      run_pass(1);   // same table under random back-pressure
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- ref_cache_bank.f
design/cache_bank_pkg.sv
design/tag_memory.sv
design/lru_age_memory.sv
design/tag_compare_stage.sv
design/cache_bank_core.sv
dv/cache_bank_tb.sv
